// ==== source/rd_matrix_pkg.sv ====
// Read matrix shared definitions
`default_nettype none

package rd_matrix_pkg;

   // --------------------
   // Geometry
   // --------------------
   localparam int NUM_SLAVES = 4;
   localparam int SLOT_W     = 2;
   localparam int DATA_W     = 64;

   // ID split into unique master field and transaction part
   localparam int UID_W = 2;
   localparam int TXN_W = 4;
   localparam int RID_W = UID_W + TXN_W;

   // --------------------
   // Master configuration
   // --------------------
   // UID this master answers to
   localparam logic [UID_W-1:0] MASTER_UID = 2'b00;

   // Set bit keeps that slot out of arbitration
   localparam logic [NUM_SLAVES-1:0] SLOT_DISABLE = 4'b0100;

   // --------------------
   // Types
   // --------------------
   // AXI read response code
   typedef logic [1:0] rresp_t;

   // Decoded ID fields, uid in the upper bits
   typedef struct packed {
      logic [UID_W-1:0] uid;
      logic [TXN_W-1:0] txn;
   } rid_fields_t;

   // Same ID word, raw for forwarding and split for decoding
   typedef union packed {
      logic [RID_W-1:0] raw;
      rid_fields_t      f;
   } rid_u;

endpackage

`default_nettype wire

// ==== source/rd_beat_if.sv ====
// Selected beat transfer
`timescale 1ns/1ps
`default_nettype none

interface rd_beat_if
   import rd_matrix_pkg::*;
   ();

   // One-cycle strobe, payload valid with it
   logic              load;
   rid_u              rid;
   logic [DATA_W-1:0] rdata;
   rresp_t            rresp;
   logic              rlast;

   // High in the cycle the held beat leaves toward the master
   logic              accepted;

   // Arbiter side
   modport src (
      output load,
      output rid,
      output rdata,
      output rresp,
      output rlast,
      input  accepted
   );

   // Output register side
   modport dst (
      input  load,
      input  rid,
      input  rdata,
      input  rresp,
      input  rlast,
      output accepted
   );

endinterface

`default_nettype wire

// ==== source/rd_slave_arbiter.sv ====
// Read slave arbiter
`timescale 1ns/1ps
`default_nettype none

module rd_slave_arbiter
   import rd_matrix_pkg::*;
   (
   input  logic                              ACLK,
   input  logic                              aresetn,

   // Slave read channels
   input  logic [NUM_SLAVES-1:0]             s_rvalid,
   input  rid_u [NUM_SLAVES-1:0]             s_rid,
   input  logic [NUM_SLAVES-1:0][DATA_W-1:0] s_rdata,
   input  rresp_t [NUM_SLAVES-1:0]           s_rresp,
   input  logic [NUM_SLAVES-1:0]             s_rlast,
   output logic [NUM_SLAVES-1:0]             s_rready,

   // Toward the output register
   rd_beat_if.src                            beat
   );

   logic [NUM_SLAVES-1:0] eligible;
   logic                  sel_found;
   logic [SLOT_W-1:0]     sel_slot;

   // Grant state
   logic                  busy;
   logic [SLOT_W-1:0]     grant_slot;

   // --------------------
   // Eligibility
   // --------------------
   // Valid, addressed to this master and not masked off
   always_comb begin
      for (int i = 0; i < NUM_SLAVES; i++) begin
         eligible[i] = s_rvalid[i]
                       && (s_rid[i].f.uid == MASTER_UID)
                       && !SLOT_DISABLE[i];
      end
   end

   // --------------------
   // Fixed priority
   // --------------------
   // Walk downward so the lowest index wins
   always_comb begin
      sel_found = 1'b0;
      sel_slot  = '0;
      for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
         if (eligible[i]) begin
            sel_found = 1'b1;
            sel_slot  = SLOT_W'(i);
         end
      end
   end

   // Load only from idle, register is empty then
   assign beat.load  = !busy && sel_found;
   assign beat.rid   = s_rid[sel_slot];
   assign beat.rdata = s_rdata[sel_slot];
   assign beat.rresp = s_rresp[sel_slot];
   assign beat.rlast = s_rlast[sel_slot];

   // --------------------
   // Grant state
   // --------------------
   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         busy       <= 1'b0;
         grant_slot <= '0;
      end
      else if (beat.load) begin
         busy       <= 1'b1;
         grant_slot <= sel_slot;
      end
      else if (busy && beat.accepted) begin
         busy       <= 1'b0;
      end
   end

   // Granted slave sees the master acceptance, others stay low
   always_comb begin
      s_rready = '0;
      if (busy) begin
         s_rready[grant_slot] = beat.accepted;
      end
   end

   // --------------------
   // Checks
   // --------------------
   // At most one slave released per cycle
   assert property (@(posedge ACLK) disable iff (!aresetn)
      $onehot0(s_rready))
      else $error("more than one slave ready at once");

   // Ready only to the slot held since the load, never a masked one
   assert property (@(posedge ACLK) disable iff (!aresetn)
      (|s_rready) |-> busy
                      && (s_rready == (NUM_SLAVES'(1) << grant_slot))
                      && ((s_rready & SLOT_DISABLE) == '0))
      else $error("slave ready outside the granted slot");

endmodule

`default_nettype wire

// ==== source/rd_beat_register.sv ====
// Master side beat register
`timescale 1ns/1ps
`default_nettype none

module rd_beat_register
   import rd_matrix_pkg::*;
   (
   input  logic              ACLK,
   input  logic              aresetn,

   // From the arbiter
   rd_beat_if.dst            beat,

   // Master read channel
   output logic              m_rvalid,
   output rid_u              m_rid,
   output logic [DATA_W-1:0] m_rdata,
   output rresp_t            m_rresp,
   output logic              m_rlast,
   input  logic              m_rready
   );

   // --------------------
   // Handshake
   // --------------------
   // Held beat taken by the master this cycle
   assign beat.accepted = m_rvalid && m_rready;

   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         m_rvalid <= 1'b0;
      end
      else if (beat.load) begin
         m_rvalid <= 1'b1;
      end
      else if (beat.accepted) begin
         m_rvalid <= 1'b0;
      end
   end

   // --------------------
   // Payload
   // --------------------
   // Captured on load, then held until the next load
   always_ff @(posedge ACLK) begin
      if (beat.load) begin
         m_rid.raw <= beat.rid.raw;
         m_rdata   <= beat.rdata;
         m_rresp   <= beat.rresp;
         m_rlast   <= beat.rlast;
      end
   end

   // --------------------
   // Checks
   // --------------------
   // Back-pressure keeps the beat on the bus unchanged
   assert property (@(posedge ACLK) disable iff (!aresetn)
      (m_rvalid && !m_rready) |=> m_rvalid
                                 && $stable(m_rid)
                                 && $stable(m_rdata)
                                 && $stable(m_rresp)
                                 && $stable(m_rlast))
      else $error("master beat changed under back-pressure");

   // Arbiter only loads into an empty register
   assert property (@(posedge ACLK) disable iff (!aresetn)
      beat.load |-> !m_rvalid)
      else $error("load while a beat is still held");

endmodule

`default_nettype wire

// ==== source/rd_matrix_top.sv ====
// Read data matrix top level
`timescale 1ns/1ps
`default_nettype none

module rd_matrix_top
   import rd_matrix_pkg::*;
   (
   input  logic                              ACLK,
   input  logic                              aresetn,

   // --------------------
   // Slave read channels
   // --------------------
   input  logic [NUM_SLAVES-1:0]             s_rvalid,
   input  rid_u [NUM_SLAVES-1:0]             s_rid,
   input  logic [NUM_SLAVES-1:0][DATA_W-1:0] s_rdata,
   input  rresp_t [NUM_SLAVES-1:0]           s_rresp,
   input  logic [NUM_SLAVES-1:0]             s_rlast,
   output logic [NUM_SLAVES-1:0]             s_rready,

   // --------------------
   // Master read channel
   // --------------------
   output logic                              m_rvalid,
   output rid_u                              m_rid,
   output logic [DATA_W-1:0]                 m_rdata,
   output rresp_t                            m_rresp,
   output logic                              m_rlast,
   input  logic                              m_rready
   );

   // Chosen beat between arbiter and register
   rd_beat_if beat_if ();

   // Picks one eligible slave and owns its ready
   rd_slave_arbiter rd_slave_arbiter_inst (
      .ACLK     (ACLK),
      .aresetn  (aresetn),
      .s_rvalid (s_rvalid),
      .s_rid    (s_rid),
      .s_rdata  (s_rdata),
      .s_rresp  (s_rresp),
      .s_rlast  (s_rlast),
      .s_rready (s_rready),
      .beat     (beat_if.src)
   );

   // Holds the beat until the master takes it
   rd_beat_register rd_beat_register_inst (
      .ACLK     (ACLK),
      .aresetn  (aresetn),
      .beat     (beat_if.dst),
      .m_rvalid (m_rvalid),
      .m_rid    (m_rid),
      .m_rdata  (m_rdata),
      .m_rresp  (m_rresp),
      .m_rlast  (m_rlast),
      .m_rready (m_rready)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_rd_slave_model.sv ====
// Random read slave
`timescale 1ns/1ps
`default_nettype none

module tb_rd_slave_model
   import rd_matrix_pkg::*;
   #(
   parameter int SLOT = 0,
   parameter int SEED = 0
   )
   (
   input  logic              ACLK,
   input  logic              aresetn,
   input  logic              ready,
   output logic              valid,
   output rid_u              rid,
   output logic [DATA_W-1:0] rdata,
   output rresp_t            rresp,
   output logic              rlast
   );

   // Cycles an unservable beat waits before it is replaced
   localparam int GIVE_UP = 20;

   integer seed;
   int     gap;
   int     age;
   logic   served;
   logic   hopeless;

   // Mostly addressed to this master, sometimes to a foreign one
   task automatic draw_beat();
      if (($unsigned($random(seed)) % 4) != 0) begin
         rid.f.uid = MASTER_UID;
      end
      else begin
         rid.f.uid = MASTER_UID ^ UID_W'(1 + ($unsigned($random(seed)) % 3));
      end
      rid.f.txn = TXN_W'($random(seed));
      rdata     = {32'($random(seed)), 32'($random(seed))};
      rresp     = 2'($random(seed));
      rlast     = 1'($random(seed));
   endtask

   initial begin
      seed  = SEED;
      valid = 1'b0;
      rid   = '0;
      rdata = '0;
      rresp = '0;
      rlast = 1'b0;
      @(posedge aresetn);
      forever begin
         gap = $unsigned($random(seed)) % 6;
         repeat (gap) @(posedge ACLK);
         @(posedge ACLK);
         #1;
         draw_beat();
         valid    = 1'b1;
         hopeless = SLOT_DISABLE[SLOT] || (rid.f.uid != MASTER_UID);
         served   = 1'b0;
         age      = 0;
         // Hold the beat until ready is seen, or give up on a lost cause
         while (!served && !(hopeless && age >= GIVE_UP)) begin
            @(negedge ACLK);
            served = ready;
            age++;
            @(posedge ACLK);
            #1;
         end
         valid = 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== testbench/tb_rd_matrix.sv ====
// Read matrix testbench
`timescale 1ns/1ps
`default_nettype none

module tb_rd_matrix
   import rd_matrix_pkg::*;
   ();

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 10;
   localparam int NUM_BEATS    = 400;
   localparam int BEAT_BUDGET  = 40;

   logic                              ACLK;
   logic                              aresetn;
   logic [NUM_SLAVES-1:0]             s_rvalid;
   rid_u [NUM_SLAVES-1:0]             s_rid;
   logic [NUM_SLAVES-1:0][DATA_W-1:0] s_rdata;
   rresp_t [NUM_SLAVES-1:0]           s_rresp;
   logic [NUM_SLAVES-1:0]             s_rlast;
   logic [NUM_SLAVES-1:0]             s_rready;
   logic                              m_rvalid;
   rid_u                              m_rid;
   logic [DATA_W-1:0]                 m_rdata;
   rresp_t                            m_rresp;
   logic                              m_rlast;
   logic                              m_rready;

   // One element per slave model
   logic              model_valid [NUM_SLAVES];
   rid_u              model_rid   [NUM_SLAVES];
   logic [DATA_W-1:0] model_data  [NUM_SLAVES];
   rresp_t            model_resp  [NUM_SLAVES];
   logic              model_last  [NUM_SLAVES];

   integer seed;
   int     value_errors = 0;
   int     other_errors = 0;
   int     accepts      = 0;
   int     ready_pulses = 0;

   // Inputs and model state from the previous cycle
   logic                              snap_aresetn   = 1'b0;
   logic [NUM_SLAVES-1:0]             snap_valid     = '0;
   rid_u [NUM_SLAVES-1:0]             snap_rid;
   logic [NUM_SLAVES-1:0][DATA_W-1:0] snap_data;
   rresp_t [NUM_SLAVES-1:0]           snap_resp;
   logic [NUM_SLAVES-1:0]             snap_last;
   logic                              snap_exp_valid = 1'b0;
   logic                              snap_m_rready  = 1'b0;

   // Beat expected on the master side
   int                exp_slot = 0;
   rid_u              exp_rid;
   logic [DATA_W-1:0] exp_data;
   rresp_t            exp_resp;
   logic              exp_last;

   rd_matrix_top rd_matrix_top_inst (
      .ACLK     (ACLK),
      .aresetn  (aresetn),
      .s_rvalid (s_rvalid),
      .s_rid    (s_rid),
      .s_rdata  (s_rdata),
      .s_rresp  (s_rresp),
      .s_rlast  (s_rlast),
      .s_rready (s_rready),
      .m_rvalid (m_rvalid),
      .m_rid    (m_rid),
      .m_rdata  (m_rdata),
      .m_rresp  (m_rresp),
      .m_rlast  (m_rlast),
      .m_rready (m_rready)
   );

   for (genvar i = 0; i < NUM_SLAVES; i++) begin : gen_slave
      tb_rd_slave_model #(.SLOT(i), .SEED(32'h44fb + i)) slave_model_inst (
         .ACLK    (ACLK),
         .aresetn (aresetn),
         .ready   (s_rready[i]),
         .valid   (model_valid[i]),
         .rid     (model_rid[i]),
         .rdata   (model_data[i]),
         .rresp   (model_resp[i]),
         .rlast   (model_last[i])
      );
   end

   always_comb begin
      for (int i = 0; i < NUM_SLAVES; i++) begin
         s_rvalid[i] = model_valid[i];
         s_rid[i]    = model_rid[i];
         s_rdata[i]  = model_data[i];
         s_rresp[i]  = model_resp[i];
         s_rlast[i]  = model_last[i];
      end
   end

   // --------------------
   // Clock, reset, master
   // --------------------
   initial begin
      ACLK = 1'b0;
      forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
   end

   // Master ready low about 40% of the cycles
   initial begin
      seed     = 32'h44fb;
      aresetn  = 1'b0;
      m_rready = 1'b0;
      repeat (RESET_CYCLES) @(posedge ACLK);
      #1;
      aresetn = 1'b1;
      forever begin
         @(posedge ACLK);
         #1;
         m_rready = (($unsigned($random(seed)) % 10) >= 4);
      end
   end

   // --------------------
   // Compare tasks
   // --------------------
   task automatic compare_rid(input string name, input rid_u expected, input rid_u actual);
      if (actual !== expected) begin
         value_errors++;
         $display("FAILED t=%0t %s expected %h actual %h", $time, name,
                  expected.raw, actual.raw);
      end
   endtask

   task automatic compare_data(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
      if (actual !== expected) begin
         value_errors++;
         $display("FAILED t=%0t %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   task automatic compare_resp(input string name, input rresp_t expected, input rresp_t actual);
      if (actual !== expected) begin
         value_errors++;
         $display("FAILED t=%0t %s expected %b actual %b", $time, name, expected, actual);
      end
   endtask

   task automatic compare_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         value_errors++;
         $display("FAILED t=%0t %s expected %b actual %b", $time, name, expected, actual);
      end
   endtask

   // Valid, addressed to this master and not masked off
   function automatic logic [NUM_SLAVES-1:0] eligible_slots(
      input logic [NUM_SLAVES-1:0] valid, input rid_u [NUM_SLAVES-1:0] ids);
      logic [NUM_SLAVES-1:0] result;
      for (int i = 0; i < NUM_SLAVES; i++) begin
         result[i] = valid[i] && (ids[i].f.uid == MASTER_UID) && !SLOT_DISABLE[i];
      end
      return result;
   endfunction

   function automatic int lowest_slot(input logic [NUM_SLAVES-1:0] set);
      for (int i = 0; i < NUM_SLAVES; i++) begin
         if (set[i]) begin
            return i;
         end
      end
      return -1;
   endfunction

   // --------------------
   // Reference model
   // --------------------
   // Mid-cycle, everything driven after the rising edge has settled
   always @(negedge ACLK) begin : check_cycle
      logic [NUM_SLAVES-1:0] elig;
      logic                  exp_valid;
      logic                  accept_now;
      if (!aresetn || !snap_aresetn) begin
         exp_valid = 1'b0;
         compare_bit("m_rvalid", 1'b0, m_rvalid);
         for (int i = 0; i < NUM_SLAVES; i++) begin
            compare_bit($sformatf("s_rready[%0d]", i), 1'b0, s_rready[i]);
         end
      end
      else begin
         elig = eligible_slots(snap_valid, snap_rid);
         if (!snap_exp_valid) begin
            // Idle last cycle, so the lowest eligible slot was loaded
            exp_valid = |elig;
            if (exp_valid) begin
               exp_slot = lowest_slot(elig);
               exp_rid  = snap_rid[exp_slot];
               exp_data = snap_data[exp_slot];
               exp_resp = snap_resp[exp_slot];
               exp_last = snap_last[exp_slot];
            end
         end
         else begin
            exp_valid = !snap_m_rready;
         end
         compare_bit("m_rvalid", exp_valid, m_rvalid);
         if (exp_valid && m_rvalid) begin
            compare_rid("m_rid", exp_rid, m_rid);
            compare_data("m_rdata", exp_data, m_rdata);
            compare_resp("m_rresp", exp_resp, m_rresp);
            compare_bit("m_rlast", exp_last, m_rlast);
         end
         accept_now = exp_valid && m_rready;
         if (accept_now) begin
            accepts++;
         end
         for (int i = 0; i < NUM_SLAVES; i++) begin
            compare_bit($sformatf("s_rready[%0d]", i),
                        accept_now && (i == exp_slot), s_rready[i]);
            if (s_rready[i] === 1'b1) begin
               ready_pulses++;
            end
         end
      end
      snap_aresetn   = aresetn;
      snap_valid     = s_rvalid;
      snap_rid       = s_rid;
      snap_data      = s_rdata;
      snap_resp      = s_rresp;
      snap_last      = s_rlast;
      snap_exp_valid = exp_valid;
      snap_m_rready  = m_rready;
   end

   // --------------------
   // Run control
   // --------------------
   task automatic finish_run();
      $display("Summary: %0d accepted, %0d ready pulses, %0d value errors, %0d other errors",
               accepts, ready_pulses, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TB PASSED");
      end
      else begin
         $display("TB FAILED");
      end
      $finish;
   endtask

   initial begin : main_flow
      wait (accepts >= NUM_BEATS);
      repeat (3) @(posedge ACLK);
      if (ready_pulses != accepts) begin
         other_errors++;
         $display("Slave ready pulses (%0d) do not match master acceptances (%0d)",
                  ready_pulses, accepts);
      end
      finish_run();
   end

   // Generous budget per beat
   initial begin : watchdog
      #(NUM_BEATS * BEAT_BUDGET * CLK_PERIOD);
      other_errors++;
      $display("Run timed out with %0d of %0d beats accepted", accepts, NUM_BEATS);
      finish_run();
   end

endmodule

`default_nettype wire

// ==== files.f ====
source/rd_matrix_pkg.sv
source/rd_beat_if.sv
source/rd_slave_arbiter.sv
source/rd_beat_register.sv
source/rd_matrix_top.sv
testbench/tb_rd_slave_model.sv
testbench/tb_rd_matrix.sv
